// ==== list.f ====
+incdir+src
src/fm_pkg.sv
src/fm_mmr.sv
src/fm_timers.sv
src/fm_pg.sv
src/fm_op.sv
src/fm_acc.sv
src/fm_top.sv
test/tb_clock.sv
test/fm_asserts.sv
test/fm_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module fm_tb -o fm_sim
	@out="$$(./obj_dir/fm_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// ==== test/fm_tb.sv ====
`include "fm_settings.svh"

module fm_tb
	import fm_pkg::*;
();

	localparam int BUSY_LIMIT   = 64;
	localparam int SAMPLE_LIMIT = 16;
	localparam int IRQ_LIMIT    = 2000;
	localparam int HALF_LIMIT   = 200;

	logic               clk_int;
	logic               reset;
	logic               cs_n;
	logic               wr_n;
	logic               addr;
	logic [7:0]         din;
	logic [7:0]         dout;
	logic               irq_n;
	logic signed [10:0] snd_left;
	logic signed [10:0] snd_right;
	logic               sample;
	int                 val_errors;
	int                 timeouts;

	tb_clock #(.PERIOD(4)) u_clock (
		.clk_int ( clk_int )
	);

	fm_top u_dut (
		.clk_int   ( clk_int   ),
		.reset     ( reset     ),
		.cs_n      ( cs_n      ),
		.wr_n      ( wr_n      ),
		.addr      ( addr      ),
		.din       ( din       ),
		.dout      ( dout      ),
		.irq_n     ( irq_n     ),
		.snd_left  ( snd_left  ),
		.snd_right ( snd_right ),
		.sample    ( sample    )
	);

	function automatic logic [7:0] key_byte(input logic [1:0] ch, input logic on);
		reg_data_u d;
		d           = '0;
		d.key.ch    = ch;
		d.key.keyon = on;
		return d.raw;
	endfunction

	function automatic logic [7:0] ctrl_byte(input logic ld_a, input logic ld_b,
			input logic en_a, input logic en_b, input logic clr_a, input logic clr_b);
		reg_data_u d;
		d                = '0;
		d.tctrl.load_a   = ld_a;
		d.tctrl.load_b   = ld_b;
		d.tctrl.irq_en_a = en_a;
		d.tctrl.irq_en_b = en_b;
		d.tctrl.clr_a    = clr_a;
		d.tctrl.clr_b    = clr_b;
		return d.raw;
	endfunction

	function automatic int magnitude(input logic signed [10:0] v);
		return (v < 0) ? -int'(v) : int'(v);
	endfunction

	task automatic report_mismatch(input string name, input int got, input int exp);
		$display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
		val_errors++;
	endtask

	// Bus cycle with the strobes low for one clock
	task automatic bus_cycle(input logic a, input logic [7:0] d);
		@(negedge clk_int);
		cs_n = 1'b0;
		wr_n = 1'b0;
		addr = a;
		din  = d;
		@(negedge clk_int);
		cs_n = 1'b1;
		wr_n = 1'b1;
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		while (dout[7] !== 1'b0 && n < BUSY_LIMIT) begin
			@(negedge clk_int);
			n++;
		end
		if (dout[7] !== 1'b0) begin
			$display("Timed out waiting for busy to clear");
			timeouts++;
		end
	endtask

	task automatic bus_write(input logic [7:0] address, input logic [7:0] data);
		bus_cycle(1'b0, address);
		wait_not_busy();
		bus_cycle(1'b1, data);
	endtask

	task automatic read_status(output logic [7:0] s);
		s = dout;
	endtask

	task automatic get_sample(output logic signed [10:0] l, output logic signed [10:0] r);
		int n;
		n = 0;
		@(negedge clk_int);
		while (sample !== 1'b1 && n < SAMPLE_LIMIT) begin
			@(negedge clk_int);
			n++;
		end
		if (sample !== 1'b1) begin
			$display("Timed out waiting for a sample strobe");
			timeouts++;
		end
		l = snd_left;
		r = snd_right;
	endtask

	task automatic skip_samples(input int count);
		logic signed [10:0] l;
		logic signed [10:0] r;
		for (int i = 0; i < count; i++) begin
			get_sample(l, r);
		end
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		while (irq_n !== level && n < IRQ_LIMIT) begin
			@(negedge clk_int);
			n++;
		end
		if (irq_n !== level) begin
			$display("Timed out waiting for irq_n to reach %0b", level);
			timeouts++;
		end
	endtask

	task automatic set_channel(input logic [1:0] ch, input logic [9:0] fnum,
			input logic [2:0] block, input logic [2:0] tl, input logic [1:0] pan);
		bus_write(8'h30 + ch, fnum[7:0]);
		bus_write(8'h34 + ch, {3'b000, block, fnum[9:8]});
		bus_write(8'h38 + ch, {pan, 3'b000, tl});
	endtask

	// Samples up to and including the next sign change
	task automatic measure_half(input logic start_neg, output int len, output logic end_neg);
		logic signed [10:0] l;
		logic signed [10:0] r;
		len = 0;
		do begin
			get_sample(l, r);
			len++;
		end while ((l < 0) == start_neg && len < HALF_LIMIT);
		end_neg = (l < 0);
	endtask

	task automatic after_reset();
		logic [7:0]         s;
		logic signed [10:0] l;
		logic signed [10:0] r;
		read_status(s);
		if (s !== 8'h00) report_mismatch("dout", s, 8'h00);
		if (irq_n !== 1'b1) report_mismatch("irq_n", irq_n, 1);
		for (int i = 0; i < 6; i++) begin
			get_sample(l, r);
			if (l !== 11'sd0) report_mismatch("snd_left", l, 0);
			if (r !== 11'sd0) report_mismatch("snd_right", r, 0);
		end
	endtask

	task automatic busy_blocks_write();
		logic [7:0]         s;
		logic signed [10:0] l;
		logic signed [10:0] r;
		int                 busy_len;
		bus_write(8'h38, {2'b11, 3'b000, 3'd2});
		read_status(s);
		if (s[7] !== 1'b1) report_mismatch("dout[7]", s[7], 1);
		// tl=7 lands while busy and must be dropped
		bus_cycle(1'b0, 8'h38);
		bus_cycle(1'b1, {2'b11, 3'b000, 3'd7});
		// Two bus cycles of two clocks each since the accepted write
		busy_len = 4;
		while (dout[7] !== 1'b0 && busy_len < BUSY_LIMIT) begin
			@(negedge clk_int);
			busy_len++;
		end
		if (busy_len != `FM_BUSY_CYCLES) begin
			report_mismatch("busy_cycles", busy_len, `FM_BUSY_CYCLES);
		end
		bus_write(8'h28, key_byte(2'd0, 1'b1));
		skip_samples(3);
		for (int i = 0; i < 4; i++) begin
			get_sample(l, r);
			if (magnitude(l) != (255 >> 2)) report_mismatch("snd_left", magnitude(l), 255 >> 2);
			if (magnitude(r) != (255 >> 2)) report_mismatch("snd_right", magnitude(r), 255 >> 2);
		end
		bus_write(8'h28, key_byte(2'd0, 1'b0));
		skip_samples(3);
	endtask

	task automatic single_tone();
		int                 ch;
		int                 fnum;
		int                 block;
		int                 tl;
		int                 mag;
		int                 expect_len;
		int                 len;
		logic               neg;
		logic signed [10:0] l;
		logic signed [10:0] r;
		ch         = $urandom % 4;
		fnum       = 512 + $urandom % 512;
		block      = 1 + $urandom % 3;
		tl         = $urandom % 8;
		mag        = 255 >> tl;
		expect_len = 32768 / (fnum << block);
		set_channel(2'(ch), 10'(fnum), 3'(block), 3'(tl), 2'b11);
		bus_write(8'h28, key_byte(2'(ch), 1'b1));
		skip_samples(3);
		for (int i = 0; i < 8; i++) begin
			get_sample(l, r);
			if (magnitude(l) != mag) report_mismatch("snd_left", magnitude(l), mag);
			if (magnitude(r) != mag) report_mismatch("snd_right", magnitude(r), mag);
		end
		// First half period is partial and only aligns
		get_sample(l, r);
		measure_half(l < 0, len, neg);
		for (int i = 0; i < 2; i++) begin
			measure_half(neg, len, neg);
			if (len < expect_len - 1 || len > expect_len + 1) begin
				report_mismatch("half_period", len, expect_len);
			end
		end
		bus_write(8'h38 + 8'(ch), {2'b10, 3'b000, 3'(tl)});
		skip_samples(3);
		for (int i = 0; i < 4; i++) begin
			get_sample(l, r);
			if (magnitude(l) != mag) report_mismatch("snd_left", magnitude(l), mag);
			if (r !== 11'sd0) report_mismatch("snd_right", r, 0);
		end
		bus_write(8'h28, key_byte(2'(ch), 1'b0));
		skip_samples(3);
		for (int i = 0; i < 4; i++) begin
			get_sample(l, r);
			if (l !== 11'sd0) report_mismatch("snd_left", l, 0);
			if (r !== 11'sd0) report_mismatch("snd_right", r, 0);
		end
	endtask

	task automatic two_channel_mix();
		int                 m1;
		int                 m2;
		logic signed [10:0] l;
		logic signed [10:0] r;
		m1 = 255 >> 1;
		m2 = 255 >> 3;
		set_channel(2'd1, 10'd700, 3'd2, 3'd1, 2'b11);
		set_channel(2'd2, 10'd900, 3'd3, 3'd3, 2'b11);
		bus_write(8'h28, key_byte(2'd1, 1'b1));
		bus_write(8'h28, key_byte(2'd2, 1'b1));
		skip_samples(3);
		for (int i = 0; i < 16; i++) begin
			get_sample(l, r);
			if (magnitude(l) != m1 + m2 && magnitude(l) != m1 - m2) begin
				report_mismatch("snd_left", magnitude(l), m1 + m2);
			end
			if (magnitude(r) != m1 + m2 && magnitude(r) != m1 - m2) begin
				report_mismatch("snd_right", magnitude(r), m1 + m2);
			end
		end
		bus_write(8'h28, key_byte(2'd1, 1'b0));
		bus_write(8'h28, key_byte(2'd2, 1'b0));
		skip_samples(3);
	endtask

	task automatic timer_a_flag();
		logic [7:0] s;
		// value_a of 1020 overflows after four frames
		bus_write(8'h20, 8'hff);
		bus_write(8'h21, 8'h00);
		bus_write(8'h27, ctrl_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		wait_irq(1'b0);
		read_status(s);
		if (s[0] !== 1'b1) report_mismatch("flag_a", s[0], 1);
		if (s[1] !== 1'b0) report_mismatch("flag_b", s[1], 0);
		bus_write(8'h27, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
		wait_irq(1'b1);
		read_status(s);
		if (s[1:0] !== 2'b00) report_mismatch("dout[1:0]", s[1:0], 0);
	endtask

	task automatic timer_b_flag();
		logic [7:0] s;
		bus_write(8'h22, 8'd254);
		bus_write(8'h27, ctrl_byte(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
		wait_irq(1'b0);
		read_status(s);
		if (s[1] !== 1'b1) report_mismatch("flag_b", s[1], 1);
		if (s[0] !== 1'b0) report_mismatch("flag_a", s[0], 0);
		bus_write(8'h27, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
		wait_irq(1'b1);
		read_status(s);
		if (s[1:0] !== 2'b00) report_mismatch("dout[1:0]", s[1:0], 0);
	endtask

	initial begin
		int assert_errors;
		reset      = 1'b1;
		cs_n       = 1'b1;
		wr_n       = 1'b1;
		addr       = 1'b0;
		din        = 8'h00;
		val_errors = 0;
		timeouts   = 0;
		void'($urandom(32'h7697));
		repeat (8) @(posedge clk_int);
		@(negedge clk_int);
		reset = 1'b0;

		after_reset();
		busy_blocks_write();
		single_tone();
		two_channel_mix();
		timer_a_flag();
		timer_b_flag();

		assert_errors = u_dut.u_asserts.fail_cnt;
		$display("Errors: %0d value, %0d timeout, %0d assertion",
			val_errors, timeouts, assert_errors);
		if (val_errors == 0 && timeouts == 0 && assert_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== test/fm_asserts.sv ====
`include "fm_settings.svh"

module fm_asserts
	import fm_pkg::*;
(
	input logic       clk_int,
	input logic       reset,
	input logic       cs_n,
	input logic       wr_n,
	input logic       addr,
	input logic [7:0] din,
	input logic [7:0] dout,
	input logic       flag_a,
	input logic       flag_b,
	input logic       sample
);

	int         fail_strobe = 0;
	int         fail_clear = 0;
	int         fail_busy = 0;
	int         fail_cnt;
	logic       data_wr;
	logic       ctrl_wr;
	logic [7:0] last_addr;
	reg_data_u  cmd;

	// Data write accepted while busy is clear
	assign data_wr  = !cs_n && !wr_n && addr && !dout[7];
	assign ctrl_wr  = data_wr && (last_addr == 8'h27);
	assign cmd      = reg_data_u'(din);
	assign fail_cnt = fail_strobe + fail_clear + fail_busy;

	// Register address as the host last wrote it
	always_ff @(posedge clk_int) begin
		if (reset) begin
			last_addr <= '0;
		end else if (!cs_n && !wr_n && !addr) begin
			last_addr <= din;
		end
	end

	// One strobe per frame
	sample_single: assert property (@(posedge clk_int) disable iff (reset)
		sample |=> !sample)
		else begin
			$error("sample high on two consecutive cycles");
			fail_strobe++;
		end

	// Clear command reaches the flag two clocks after the write
	clear_a: assert property (@(posedge clk_int) disable iff (reset)
		(ctrl_wr && cmd.tctrl.clr_a) |-> ##2 !flag_a)
		else begin
			$error("flag_a still set after a clear command");
			fail_clear++;
		end

	clear_b: assert property (@(posedge clk_int) disable iff (reset)
		(ctrl_wr && cmd.tctrl.clr_b) |-> ##2 !flag_b)
		else begin
			$error("flag_b still set after a clear command");
			fail_clear++;
		end

	busy_ends: assert property (@(posedge clk_int) disable iff (reset)
		data_wr |-> ##(`FM_BUSY_CYCLES + 1) !dout[7])
		else begin
			$error("busy still set after a data write");
			fail_busy++;
		end

endmodule

bind fm_top fm_asserts u_asserts (
	.clk_int ( clk_int ),
	.reset   ( reset   ),
	.cs_n    ( cs_n    ),
	.wr_n    ( wr_n    ),
	.addr    ( addr    ),
	.din     ( din     ),
	.dout    ( dout    ),
	.flag_a  ( flag_a  ),
	.flag_b  ( flag_b  ),
	.sample  ( sample  )
);

// ==== test/tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clk_int
);

	initial begin
		clk_int = 1'b0;
		forever begin
			#(PERIOD / 2) clk_int = ~clk_int;
		end
	end

endmodule

// ==== src/fm_top.sv ====
`include "fm_settings.svh"

module fm_top
	import fm_pkg::*;
(
	input  logic               clk_int,
	input  logic               reset,
	input  logic               cs_n,
	input  logic               wr_n,
	input  logic               addr,
	input  logic [7:0]         din,
	output logic [7:0]         dout,
	output logic               irq_n,
	output logic signed [10:0] snd_left,
	output logic signed [10:0] snd_right,
	output logic               sample
);

	logic                            flag_a;
	logic                            flag_b;
	logic                            zero;
	logic [$clog2(`FM_CHANNELS)-1:0] slot;
	chan_cfg_t                       slot_cfg;
	timer_cfg_t                      tcfg;
	op_in_t                          op_in;
	op_out_t                         op_out;

	fm_mmr u_mmr (
		.clk_int  ( clk_int  ),
		.reset    ( reset    ),
		.cs_n     ( cs_n     ),
		.wr_n     ( wr_n     ),
		.addr     ( addr     ),
		.din      ( din      ),
		.flag_a   ( flag_a   ),
		.flag_b   ( flag_b   ),
		.dout     ( dout     ),
		.zero     ( zero     ),
		.slot     ( slot     ),
		.slot_cfg ( slot_cfg ),
		.tcfg     ( tcfg     )
	);

	// Timers step once per frame
	fm_timers u_timers (
		.clk_int ( clk_int ),
		.reset   ( reset   ),
		.zero    ( zero    ),
		.tcfg    ( tcfg    ),
		.flag_a  ( flag_a  ),
		.flag_b  ( flag_b  ),
		.irq_n   ( irq_n   )
	);

	fm_pg u_pg (
		.clk_int  ( clk_int  ),
		.reset    ( reset    ),
		.slot     ( slot     ),
		.slot_cfg ( slot_cfg ),
		.op_in    ( op_in    )
	);

	fm_op u_op (
		.clk_int ( clk_int ),
		.reset   ( reset   ),
		.op_in   ( op_in   ),
		.op_out  ( op_out  )
	);

	fm_acc u_acc (
		.clk_int   ( clk_int   ),
		.reset     ( reset     ),
		.op_out    ( op_out    ),
		.snd_left  ( snd_left  ),
		.snd_right ( snd_right ),
		.sample    ( sample    )
	);

endmodule

// ==== src/fm_acc.sv ====
module fm_acc
	import fm_pkg::*;
(
	input  logic               clk_int,
	input  logic               reset,
	input  op_out_t            op_out,
	output logic signed [10:0] snd_left,
	output logic signed [10:0] snd_right,
	output logic               sample
);

	logic signed [10:0] sum_l;
	logic signed [10:0] sum_r;
	logic signed [10:0] add_l;
	logic signed [10:0] add_r;
	logic signed [10:0] next_l;
	logic signed [10:0] next_r;

	// pan[1] enables left, pan[0] right
	assign add_l  = op_out.pan[1] ? {{2{op_out.value[8]}}, op_out.value} : '0;
	assign add_r  = op_out.pan[0] ? {{2{op_out.value[8]}}, op_out.value} : '0;
	assign next_l = sum_l + add_l;
	assign next_r = sum_r + add_r;

	always_ff @(posedge clk_int) begin
		if (reset) begin
			sum_l     <= '0;
			sum_r     <= '0;
			snd_left  <= '0;
			snd_right <= '0;
			sample    <= 1'b0;
		end else begin
			sample <= op_out.last;
			if (op_out.last) begin
				// Frame complete, publish and restart
				snd_left  <= next_l;
				snd_right <= next_r;
				sum_l     <= '0;
				sum_r     <= '0;
			end else begin
				sum_l <= next_l;
				sum_r <= next_r;
			end
		end
	end

endmodule

// ==== src/fm_op.sv ====
module fm_op
	import fm_pkg::*;
(
	input  logic    clk_int,
	input  logic    reset,
	input  op_in_t  op_in,
	output op_out_t op_out
);

	logic [8:0] mag;

	// 6 dB per tl step
	assign mag = {1'b0, 8'hff >> op_in.tl};

	always_ff @(posedge clk_int) begin
		if (reset) begin
			op_out <= '0;
		end else begin
			op_out.pan  <= op_in.pan;
			op_out.last <= op_in.last;
			if (!op_in.keyon) begin
				op_out.value <= '0;
			end else if (op_in.phase_msb) begin
				op_out.value <= -mag;
			end else begin
				op_out.value <= mag;
			end
		end
	end

endmodule

// ==== src/fm_pg.sv ====
`include "fm_settings.svh"

module fm_pg
	import fm_pkg::*;
(
	input  logic                            clk_int,
	input  logic                            reset,
	input  logic [$clog2(`FM_CHANNELS)-1:0] slot,
	input  chan_cfg_t                       slot_cfg,
	output op_in_t                          op_in
);

	localparam int SLOT_W = $clog2(`FM_CHANNELS);

	logic [`FM_PHASE_W-1:0] phase [`FM_CHANNELS];
	logic [`FM_PHASE_W+6:0] inc_full;
	logic [`FM_PHASE_W-1:0] next_phase;

	// Block acts as an octave shift on fnum
	assign inc_full   = {{(`FM_PHASE_W - 3){1'b0}}, slot_cfg.fnum} << slot_cfg.block;
	assign next_phase = phase[slot] + inc_full[`FM_PHASE_W-1:0];

	always_ff @(posedge clk_int) begin
		if (reset) begin
			for (int i = 0; i < `FM_CHANNELS; i++) begin
				phase[i] <= '0;
			end
			op_in <= '0;
		end else begin
			phase[slot]     <= next_phase;
			op_in.phase_msb <= next_phase[`FM_PHASE_W-1];
			op_in.tl        <= slot_cfg.tl;
			op_in.pan       <= slot_cfg.pan;
			op_in.keyon     <= slot_cfg.keyon;
			op_in.last      <= (slot == SLOT_W'(`FM_CHANNELS - 1));
		end
	end

endmodule

// ==== src/fm_timers.sv ====
`include "fm_settings.svh"

module fm_timers
	import fm_pkg::*;
(
	input  logic       clk_int,
	input  logic       reset,
	input  logic       zero,
	input  timer_cfg_t tcfg,
	output logic       flag_a,
	output logic       flag_b,
	output logic       irq_n
);

	localparam int PRE_W = $clog2(`FM_TB_PRESCALE);

	logic [9:0]       cnt_a;
	logic [7:0]       cnt_b;
	logic [PRE_W-1:0] pre_cnt;
	logic             tick_b;
	logic             ovf_a;
	logic             ovf_b;

	// Load bits in the control byte keep the timers running
	assign ovf_a  = zero && tcfg.ctrl.load_a && (cnt_a == 10'h3ff);
	assign tick_b = zero && (pre_cnt == PRE_W'(`FM_TB_PRESCALE - 1));
	assign ovf_b  = tick_b && tcfg.ctrl.load_b && (cnt_b == 8'hff);

	// Reload on a load command or on overflow
	always_ff @(posedge clk_int) begin
		if (reset) begin
			cnt_a <= '0;
		end else if (tcfg.load_a_p || ovf_a) begin
			cnt_a <= tcfg.value_a;
		end else if (zero && tcfg.ctrl.load_a) begin
			cnt_a <= cnt_a + 10'd1;
		end
	end

	// Frame prescaler for timer B restarts on load
	always_ff @(posedge clk_int) begin
		if (reset || tcfg.load_b_p) begin
			pre_cnt <= '0;
		end else if (zero) begin
			pre_cnt <= tick_b ? '0 : pre_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_int) begin
		if (reset) begin
			cnt_b <= '0;
		end else if (tcfg.load_b_p || ovf_b) begin
			cnt_b <= tcfg.value_b;
		end else if (tick_b && tcfg.ctrl.load_b) begin
			cnt_b <= cnt_b + 8'd1;
		end
	end

	// Clear wins over a coincident overflow
	always_ff @(posedge clk_int) begin
		if (reset) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (tcfg.clr_a_p) begin
				flag_a <= 1'b0;
			end else if (ovf_a && tcfg.ctrl.irq_en_a) begin
				flag_a <= 1'b1;
			end
			if (tcfg.clr_b_p) begin
				flag_b <= 1'b0;
			end else if (ovf_b && tcfg.ctrl.irq_en_b) begin
				flag_b <= 1'b1;
			end
		end
	end

	assign irq_n = !(flag_a || flag_b);

endmodule

// ==== src/fm_mmr.sv ====
`include "fm_settings.svh"

module fm_mmr
	import fm_pkg::*;
(
	input  logic                              clk_int,
	input  logic                              reset,
	input  logic                              cs_n,
	input  logic                              wr_n,
	input  logic                              addr,
	input  logic [7:0]                        din,
	input  logic                              flag_a,
	input  logic                              flag_b,
	output logic [7:0]                        dout,
	output logic                              zero,
	output logic [$clog2(`FM_CHANNELS)-1:0]   slot,
	output chan_cfg_t                         slot_cfg,
	output timer_cfg_t                        tcfg
);

	localparam int SLOT_W = $clog2(`FM_CHANNELS);
	localparam int BUSY_W = $clog2(`FM_BUSY_CYCLES + 1);

	reg_data_u         wdata;
	logic [7:0]        reg_addr;
	logic [BUSY_W-1:0] busy_cnt;
	logic              busy;
	logic              bus_wr;
	logic              addr_wr;
	logic              data_wr;
	logic              ctrl_wr;
	logic [SLOT_W-1:0] ch_sel;
	logic [SLOT_W-1:0] key_ch;
	chan_cfg_t         cfg [`FM_CHANNELS];
	logic [9:0]        value_a;
	logic [7:0]        value_b;
	timer_ctrl_t       ctrl_q;
	logic              load_a_p;
	logic              load_b_p;
	logic              clr_a_p;
	logic              clr_b_p;

	assign wdata   = reg_data_u'(din);
	assign bus_wr  = !cs_n && !wr_n;
	assign addr_wr = bus_wr && !addr;
	// Data writes during busy are dropped
	assign data_wr = bus_wr && addr && !busy;
	assign ctrl_wr = data_wr && (reg_addr == 8'h27);
	assign ch_sel  = SLOT_W'(reg_addr[1:0]);
	assign key_ch  = SLOT_W'(wdata.key.ch);
	assign busy    = (busy_cnt != '0);

	always_ff @(posedge clk_int) begin
		if (reset) begin
			reg_addr <= '0;
		end else if (addr_wr) begin
			reg_addr <= din;
		end
	end

	always_ff @(posedge clk_int) begin
		if (reset) begin
			busy_cnt <= '0;
		end else if (data_wr) begin
			busy_cnt <= BUSY_W'(`FM_BUSY_CYCLES);
		end else if (busy) begin
			busy_cnt <= busy_cnt - 1'b1;
		end
	end

	// Channel registers, 0x30..0x3B plus key command
	always_ff @(posedge clk_int) begin
		if (reset) begin
			for (int i = 0; i < `FM_CHANNELS; i++) begin
				cfg[i] <= '0;
			end
		end else if (data_wr) begin
			case (reg_addr[7:2])
				6'b001100: cfg[ch_sel].fnum[7:0] <= din;
				6'b001101: begin
					cfg[ch_sel].block     <= din[4:2];
					cfg[ch_sel].fnum[9:8] <= din[1:0];
				end
				6'b001110: begin
					cfg[ch_sel].pan <= din[7:6];
					cfg[ch_sel].tl  <= din[2:0];
				end
				default: ;
			endcase
			if (reg_addr == 8'h28) begin
				cfg[key_ch].keyon <= wdata.key.keyon;
			end
		end
	end

	// Timer reload values
	always_ff @(posedge clk_int) begin
		if (data_wr) begin
			case (reg_addr)
				8'h20: value_a[9:2] <= din;
				8'h21: value_a[1:0] <= din[1:0];
				8'h22: value_b <= din;
				default: ;
			endcase
		end
	end

	// Control byte and its one-cycle commands
	always_ff @(posedge clk_int) begin
		if (reset) begin
			ctrl_q   <= '0;
			load_a_p <= 1'b0;
			load_b_p <= 1'b0;
			clr_a_p  <= 1'b0;
			clr_b_p  <= 1'b0;
		end else begin
			load_a_p <= ctrl_wr && wdata.tctrl.load_a;
			load_b_p <= ctrl_wr && wdata.tctrl.load_b;
			clr_a_p  <= ctrl_wr && wdata.tctrl.clr_a;
			clr_b_p  <= ctrl_wr && wdata.tctrl.clr_b;
			if (ctrl_wr) begin
				ctrl_q <= wdata.tctrl;
			end
		end
	end

	assign tcfg.value_a  = value_a;
	assign tcfg.value_b  = value_b;
	assign tcfg.ctrl     = ctrl_q;
	assign tcfg.load_a_p = load_a_p;
	assign tcfg.load_b_p = load_b_p;
	assign tcfg.clr_a_p  = clr_a_p;
	assign tcfg.clr_b_p  = clr_b_p;

	// Round-robin slot sequencer
	always_ff @(posedge clk_int) begin
		if (reset) begin
			slot <= '0;
		end else if (slot == SLOT_W'(`FM_CHANNELS - 1)) begin
			slot <= '0;
		end else begin
			slot <= slot + 1'b1;
		end
	end

	assign zero     = (slot == '0);
	assign slot_cfg = cfg[slot];
	assign dout     = {busy, 5'b00000, flag_b, flag_a};

endmodule

// ==== src/fm_pkg.sv ====
package fm_pkg;

	// Per-channel register set
	typedef struct packed {
		logic [9:0] fnum;
		logic [2:0] block;
		logic [2:0] tl;
		logic [1:0] pan;
		logic       keyon;
	} chan_cfg_t;

	// Phase generator to operator
	typedef struct packed {
		logic       phase_msb;
		logic [2:0] tl;
		logic [1:0] pan;
		logic       keyon;
		logic       last;
	} op_in_t;

	// Operator to accumulator
	typedef struct packed {
		logic signed [8:0] value;
		logic [1:0]        pan;
		logic              last;
	} op_out_t;

	// Data byte of register 0x27
	typedef struct packed {
		logic [1:0] unused;
		logic       clr_b;
		logic       clr_a;
		logic       irq_en_b;
		logic       irq_en_a;
		logic       load_b;
		logic       load_a;
	} timer_ctrl_t;

	// Data byte of register 0x28
	typedef struct packed {
		logic [2:0] unused_hi;
		logic       keyon;
		logic [1:0] unused_lo;
		logic [1:0] ch;
	} key_cmd_t;

	// One data byte, read according to the latched address
	typedef union packed {
		logic [7:0]  raw;
		timer_ctrl_t tctrl;
		key_cmd_t    key;
	} reg_data_u;

	// Timer settings and command pulses
	typedef struct packed {
		logic [9:0]  value_a;
		logic [7:0]  value_b;
		timer_ctrl_t ctrl;
		logic        load_a_p;
		logic        load_b_p;
		logic        clr_a_p;
		logic        clr_b_p;
	} timer_cfg_t;

endpackage

// ==== src/fm_settings.svh ====
`ifndef FM_SETTINGS_SVH
`define FM_SETTINGS_SVH

// Channels served by the slot sequencer, one slot per channel
`define FM_CHANNELS 4

// Phase accumulator width, MSB is the square-wave sign
`define FM_PHASE_W 16

// Busy time after a data write, in clock cycles
`define FM_BUSY_CYCLES 8

// Frames per timer B count
`define FM_TB_PRESCALE 16

`endif
